/* core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

  // register value, index and instruction word
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`INST_WIDTH-1:0] inst_t;

  // shift amount field
  typedef logic [`SHAMT_MSB-`SHAMT_LSB:0] shamt_t;

  // alu operations, immediates map onto add and or
  typedef enum logic [2:0] {
    alu_nop,
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_slt
  } alu_op_t;

endpackage

/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and register file sizes
`define DATA_WIDTH 32
`define NUM_REGS 32
`define REG_ADDR_BITS 5
`define INST_WIDTH 32
`define NUM_LANES 2

// instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16
`define RD_MSB 15
`define RD_LSB 11
`define SHAMT_MSB 10
`define SHAMT_LSB 6
`define IMM_MSB 15
`define IMM_LSB 0

// opcodes
`define OP_NOP 6'd0
`define OP_ADD 6'd1
`define OP_SUB 6'd2
`define OP_AND 6'd3
`define OP_OR 6'd4
`define OP_XOR 6'd5
`define OP_SLL 6'd6
`define OP_SLT 6'd7
`define OP_ADDI 6'd8
`define OP_ORI 6'd9

`endif

/* core_trace.txt */
# test gap inst0 inst1 write0 dst0 data0 write1 dst1 data1
# test, gap, write and dst are decimal; instructions and data are hex
# gap 1 allows random idle cycles before the pair, gap 0 issues it right after the last one

# nop pairs write nothing
1 1 00000000 00000000 0 0 00000000 0 0 00000000
1 1 00000000 00221800 0 0 00000000 0 0 00000000

# immediates, zero extended
2 1 20011234 2402ffff 1 1 00001234 1 2 0000ffff
2 1 20038000 20040005 1 3 00008000 1 4 00000005

# register format ops and signed slt
3 1 04222800 08813000 1 5 00011233 1 6 ffffedd1
3 1 0c223800 10234000 1 7 00001234 1 8 00009234
3 1 14224800 18045200 1 9 0000edcb 1 10 00000500
3 1 1cc45800 1c866000 1 11 00000001 1 12 00000000

# distance one, both lanes forward from execute
4 1 200d0010 200e0020 1 13 00000010 1 14 00000020
4 0 05ae7800 09cd8000 1 15 00000030 1 16 00000010
4 0 05f08800 26120f00 1 17 00000040 1 18 00000f10

# distance two and three, lane 1 wins on a shared destination
5 1 20130100 20130200 1 19 00000100 1 19 00000200
5 0 20140003 00000000 1 20 00000003 0 0 00000000
5 0 0674a800 1260b000 1 21 00000203 1 22 00000200
5 0 0a74b800 16b6c000 1 23 000001fd 1 24 00000003
5 1 20190aaa 20190bbb 1 25 00000aaa 1 25 00000bbb
5 0 1320d000 00000000 1 26 00000bbb 0 0 00000000

# within a pair the other lane sees the old value
6 1 200d0777 05a0e000 1 13 00000777 1 28 00000010
6 0 05a0e800 0b8df000 1 29 00000777 1 30 fffff899
6 1 11c0f800 200e0055 1 31 00000020 1 14 00000055

# writes to r0 and unknown opcodes are dropped
7 1 20801111 04220000 0 0 00000000 0 0 00000000
7 0 04053800 fc051234 1 7 00011233 0 0 00000000
7 1 28222800 10a04000 0 0 00000000 1 8 00011233
7 1 10006800 08047000 1 13 00000000 1 14 fffffffb

# wide values, overflow and signed compares
8 1 18030c00 1fc61000 1 1 80000000 1 2 00000000
8 0 1c241800 1cde2000 1 3 00000001 1 4 00000001
8 0 08242800 04213000 1 5 7fffffff 1 6 00000000
8 1 14a13800 0ca94000 1 7 ffffffff 1 8 0000edcb
8 0 1ce64800 1cc75000 1 9 00000001 1 10 00000000
8 0 24eb1234 20ec0001 1 11 ffffffff 1 12 00000000

/* dual_issue_core.sv */
`timescale 1ns/1ps

`include "core_settings.svh"

module dual_issue_core (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  issue_valid,
  input  core_pkg::inst_t     [`NUM_LANES-1:0]  instruction,
  output logic                [`NUM_LANES-1:0]  wb_write,
  output core_pkg::reg_addr_t [`NUM_LANES-1:0]  wb_dst,
  output core_pkg::data_t     [`NUM_LANES-1:0]  wb_data
);

  core_pkg::reg_addr_t [`NUM_LANES-1:0][1:0] rd_addr;
  core_pkg::data_t [`NUM_LANES-1:0][1:0] rd_data;

  logic [`NUM_LANES-1:0] lane_write;
  core_pkg::alu_op_t [`NUM_LANES-1:0] lane_op;
  core_pkg::data_t [`NUM_LANES-1:0] lane_a;
  core_pkg::data_t [`NUM_LANES-1:0] lane_b;
  core_pkg::shamt_t [`NUM_LANES-1:0] lane_shamt;
  core_pkg::reg_addr_t [`NUM_LANES-1:0] lane_dst;

  // execute stage results for forwarding
  logic [`NUM_LANES-1:0] ex_write;
  core_pkg::reg_addr_t [`NUM_LANES-1:0] ex_dst;
  core_pkg::data_t [`NUM_LANES-1:0] ex_result;

  issue_decode issue_decode_inst (
    .issue_valid (issue_valid),
    .instruction (instruction),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .ex_write    (ex_write),
    .ex_dst      (ex_dst),
    .ex_result   (ex_result),
    .wb_write    (wb_write),
    .wb_dst      (wb_dst),
    .wb_data     (wb_data),
    .lane_write  (lane_write),
    .lane_op     (lane_op),
    .lane_a      (lane_a),
    .lane_b      (lane_b),
    .lane_shamt  (lane_shamt),
    .lane_dst    (lane_dst)
  );

  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
    execute_lane execute_lane_inst (
      .clk        (clk),
      .reset      (reset),
      .lane_write (lane_write[l]),
      .lane_op    (lane_op[l]),
      .lane_a     (lane_a[l]),
      .lane_b     (lane_b[l]),
      .lane_shamt (lane_shamt[l]),
      .lane_dst   (lane_dst[l]),
      .ex_write   (ex_write[l]),
      .ex_dst     (ex_dst[l]),
      .ex_result  (ex_result[l]),
      .wb_write   (wb_write[l]),
      .wb_dst     (wb_dst[l]),
      .wb_data    (wb_data[l])
    );
  end

  register_file register_file_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_write (wb_write),
    .wb_dst   (wb_dst),
    .wb_data  (wb_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* execute_lane.sv */
`timescale 1ns/1ps

`include "core_settings.svh"

module execute_lane (
  input  logic                clk,
  input  logic                reset,
  input  logic                lane_write,
  input  core_pkg::alu_op_t   lane_op,
  input  core_pkg::data_t     lane_a,
  input  core_pkg::data_t     lane_b,
  input  core_pkg::shamt_t    lane_shamt,
  input  core_pkg::reg_addr_t lane_dst,
  output logic                ex_write,
  output core_pkg::reg_addr_t ex_dst,
  output core_pkg::data_t     ex_result,
  output logic                wb_write,
  output core_pkg::reg_addr_t wb_dst,
  output core_pkg::data_t     wb_data
);

  core_pkg::alu_op_t iss_op;
  core_pkg::data_t iss_a;
  core_pkg::data_t iss_b;
  core_pkg::shamt_t iss_shamt;

  //////////////////////////////
  // issue register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_write <= 1'b0;
    end else begin
      ex_write <= lane_write;
    end
  end

  always_ff @(posedge clk) begin
    iss_op <= lane_op;
    iss_a <= lane_a;
    iss_b <= lane_b;
    iss_shamt <= lane_shamt;
    ex_dst <= lane_dst;
  end

  //////////////////////////////
  // alu
  //////////////////////////////
  always_comb begin
    case (iss_op)
      core_pkg::alu_add: ex_result = iss_a + iss_b;
      core_pkg::alu_sub: ex_result = iss_a - iss_b;
      core_pkg::alu_and: ex_result = iss_a & iss_b;
      core_pkg::alu_or:  ex_result = iss_a | iss_b;
      core_pkg::alu_xor: ex_result = iss_a ^ iss_b;
      // sll shifts the rt operand
      core_pkg::alu_sll: ex_result = iss_b << iss_shamt;
      core_pkg::alu_slt: ex_result = core_pkg::data_t'($signed(iss_a) < $signed(iss_b));
      default:           ex_result = '0;
    endcase
  end

  //////////////////////////////
  // write-back register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write <= 1'b0;
    end else begin
      wb_write <= ex_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_dst <= ex_dst;
    wb_data <= ex_result;
  end

  // a writing op reaches execute as a real alu operation
  assert property (@(posedge clk) disable iff (reset)
    lane_write |=> !$isunknown(iss_op) && iss_op != core_pkg::alu_nop)
    else $error("execute_lane: issued write without a legal alu operation");

endmodule

/* issue_decode.sv */
`timescale 1ns/1ps

`include "core_settings.svh"

module issue_decode (
  input  logic                                        issue_valid,
  input  core_pkg::inst_t     [`NUM_LANES-1:0]        instruction,
  output core_pkg::reg_addr_t [`NUM_LANES-1:0][1:0]   rd_addr,
  input  core_pkg::data_t     [`NUM_LANES-1:0][1:0]   rd_data,
  input  logic                [`NUM_LANES-1:0]        ex_write,
  input  core_pkg::reg_addr_t [`NUM_LANES-1:0]        ex_dst,
  input  core_pkg::data_t     [`NUM_LANES-1:0]        ex_result,
  input  logic                [`NUM_LANES-1:0]        wb_write,
  input  core_pkg::reg_addr_t [`NUM_LANES-1:0]        wb_dst,
  input  core_pkg::data_t     [`NUM_LANES-1:0]        wb_data,
  output logic                [`NUM_LANES-1:0]        lane_write,
  output core_pkg::alu_op_t   [`NUM_LANES-1:0]        lane_op,
  output core_pkg::data_t     [`NUM_LANES-1:0]        lane_a,
  output core_pkg::data_t     [`NUM_LANES-1:0]        lane_b,
  output core_pkg::shamt_t    [`NUM_LANES-1:0]        lane_shamt,
  output core_pkg::reg_addr_t [`NUM_LANES-1:0]        lane_dst
);

  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
    logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::reg_addr_t rd;
    logic [`IMM_MSB-`IMM_LSB:0] imm;
    core_pkg::alu_op_t op;
    logic writes;
    logic use_imm;
    logic dst_rd;
    core_pkg::data_t [1:0] operand;

    assign opcode = instruction[l][`OPCODE_MSB:`OPCODE_LSB];
    assign rs = instruction[l][`RS_MSB:`RS_LSB];
    assign rt = instruction[l][`RT_MSB:`RT_LSB];
    assign rd = instruction[l][`RD_MSB:`RD_LSB];
    assign imm = instruction[l][`IMM_MSB:`IMM_LSB];

    // port 0 reads rs, port 1 reads rt
    assign rd_addr[l][0] = rs;
    assign rd_addr[l][1] = rt;

    //////////////////////////////
    // opcode decode
    //////////////////////////////
    always_comb begin
      op = core_pkg::alu_nop;
      writes = 1'b0;
      use_imm = 1'b0;
      dst_rd = 1'b0;
      case (opcode)
        `OP_ADD: begin op = core_pkg::alu_add; writes = 1'b1; dst_rd = 1'b1; end
        `OP_SUB: begin op = core_pkg::alu_sub; writes = 1'b1; dst_rd = 1'b1; end
        `OP_AND: begin op = core_pkg::alu_and; writes = 1'b1; dst_rd = 1'b1; end
        `OP_OR:  begin op = core_pkg::alu_or;  writes = 1'b1; dst_rd = 1'b1; end
        `OP_XOR: begin op = core_pkg::alu_xor; writes = 1'b1; dst_rd = 1'b1; end
        `OP_SLL: begin op = core_pkg::alu_sll; writes = 1'b1; dst_rd = 1'b1; end
        `OP_SLT: begin op = core_pkg::alu_slt; writes = 1'b1; dst_rd = 1'b1; end
        `OP_ADDI: begin op = core_pkg::alu_add; writes = 1'b1; use_imm = 1'b1; end
        `OP_ORI:  begin op = core_pkg::alu_or;  writes = 1'b1; use_imm = 1'b1; end
        // nop and unknown opcodes fall through
        default: begin op = core_pkg::alu_nop; end
      endcase
    end

    //////////////////////////////
    // operand forwarding
    //////////////////////////////
    // later assignments win: ex over wb over regfile, higher lane over lower
    always_comb begin
      for (int p = 0; p < 2; p++) begin
        operand[p] = rd_data[l][p];
        for (int j = 0; j < `NUM_LANES; j++) begin
          if (wb_write[j] && wb_dst[j] == rd_addr[l][p])
            operand[p] = wb_data[j];
        end
        for (int j = 0; j < `NUM_LANES; j++) begin
          if (ex_write[j] && ex_dst[j] == rd_addr[l][p])
            operand[p] = ex_result[j];
        end
        if (rd_addr[l][p] == '0)
          operand[p] = '0;
      end
    end

    assign lane_op[l] = op;
    assign lane_dst[l] = dst_rd ? rd : rt;
    assign lane_write[l] = issue_valid && writes && (lane_dst[l] != '0);
    assign lane_a[l] = operand[0];
    // immediate is zero extended
    assign lane_b[l] = use_imm ? core_pkg::data_t'(imm) : operand[1];
    assign lane_shamt[l] = instruction[l][`SHAMT_MSB:`SHAMT_LSB];
  end

  // testbench must never issue undriven instruction bits
  always_comb begin
    if (issue_valid === 1'b1)
      assert final (!$isunknown(instruction))
        else $error("issue_decode: instruction has unknown bits at issue");
  end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

`include "core_settings.svh"

module register_file (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                [`NUM_LANES-1:0]        wb_write,
  input  core_pkg::reg_addr_t [`NUM_LANES-1:0]        wb_dst,
  input  core_pkg::data_t     [`NUM_LANES-1:0]        wb_data,
  input  core_pkg::reg_addr_t [`NUM_LANES-1:0][1:0]   rd_addr,
  output core_pkg::data_t     [`NUM_LANES-1:0][1:0]   rd_data
);

  core_pkg::data_t regs [`NUM_REGS];

  // lanes applied in order so the highest lane wins
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end else begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (wb_write[l] && wb_dst[l] != '0)
          regs[wb_dst[l]] <= wb_data[l];
      end
    end
  end

  // combinational reads, r0 hardwired
  always_comb begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      for (int p = 0; p < 2; p++) begin
        if (rd_addr[l][p] == '0)
          rd_data[l][p] = '0;
        else
          rd_data[l][p] = regs[rd_addr[l][p]];
      end
    end
  end

  // decode must have dropped writes to r0
  for (genvar l = 0; l < `NUM_LANES; l++) begin : g_chk
    assert property (@(posedge clk) disable iff (reset)
      wb_write[l] |-> wb_dst[l] != '0)
      else $error("register_file: lane %0d writes register 0", l);
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_dual_issue_core -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -q "^Finished with no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+.
core_pkg.sv
issue_decode.sv
execute_lane.sv
register_file.sv
dual_issue_core.sv
tb_dual_issue_core.sv

/* tb_dual_issue_core.sv */
`timescale 1ns/1ps

`include "core_settings.svh"

module tb_dual_issue_core;

  localparam int MAX_LINES = 64;
  localparam int RESET_CYCLES = 10;
  localparam int RESET_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT = 20;

  // one entry per driven cycle, idle cycles included
  typedef struct packed {
    logic real_op;
    logic last;
    logic [31:0] test;
    logic [`NUM_LANES-1:0] write;
    logic [`NUM_LANES-1:0][`REG_ADDR_BITS-1:0] dst;
    logic [`NUM_LANES-1:0][`DATA_WIDTH-1:0] data;
  } expect_t;

  logic clk;
  logic reset;
  logic issue_valid;
  core_pkg::inst_t [`NUM_LANES-1:0] instruction;
  logic [`NUM_LANES-1:0] wb_write;
  core_pkg::reg_addr_t [`NUM_LANES-1:0] wb_dst;
  core_pkg::data_t [`NUM_LANES-1:0] wb_data;

  // trace contents, two lanes per line
  int line_count = 0;
  int tr_test [MAX_LINES];
  int tr_gap [MAX_LINES];
  core_pkg::inst_t tr_inst [MAX_LINES][2];
  logic tr_write [MAX_LINES][2];
  core_pkg::reg_addr_t tr_dst [MAX_LINES][2];
  core_pkg::data_t tr_data [MAX_LINES][2];

  expect_t expect_q [$];
  expect_t cur_exp;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int test_errors = 0;
  int pending_real = 0;
  integer seed;
  logic released;

  dual_issue_core dual_issue_core_inst (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .instruction (instruction),
    .wb_write    (wb_write),
    .wb_dst      (wb_dst),
    .wb_data     (wb_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  initial begin
    reset = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++)
      @(posedge clk);
    reset <= 1'b0;
  end

  //////////////////////////////
  // trace loading
  //////////////////////////////
  task automatic load_trace();
    int fd;
    int fields;
    int t_test;
    int t_gap;
    int w0;
    int d0;
    int w1;
    int d1;
    logic [31:0] i0;
    logic [31:0] i1;
    logic [31:0] v0;
    logic [31:0] v1;
    string line;
    fd = $fopen("core_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open core_trace.txt");
      error_count++;
      return;
    end
    while (!$feof(fd) && line_count < MAX_LINES) begin
      line = "";
      if ($fgets(line, fd) == 0)
        break;
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      fields = $sscanf(line, "%d %d %h %h %d %d %h %d %d %h",
                       t_test, t_gap, i0, i1, w0, d0, v0, w1, d1, v1);
      if (fields != 10) begin
        $display("trace line could not be parsed: %s", line);
        error_count++;
      end else begin
        tr_test[line_count] = t_test;
        tr_gap[line_count] = t_gap;
        tr_inst[line_count][0] = i0;
        tr_inst[line_count][1] = i1;
        tr_write[line_count][0] = (w0 != 0);
        tr_write[line_count][1] = (w1 != 0);
        tr_dst[line_count][0] = core_pkg::reg_addr_t'(d0);
        tr_dst[line_count][1] = core_pkg::reg_addr_t'(d1);
        tr_data[line_count][0] = v0;
        tr_data[line_count][1] = v1;
        line_count++;
      end
    end
    $fclose(fd);
    if (line_count == 0) begin
      $display("trace holds no instruction pairs");
      error_count++;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic issue_pair(input logic valid, input core_pkg::inst_t i0,
                            input core_pkg::inst_t i1, input expect_t e);
    @(posedge clk);
    issue_valid <= valid;
    instruction[0] <= i0;
    instruction[1] <= i1;
    expect_q.push_back(e);
    if (e.real_op)
      pending_real++;
  endtask

  task automatic issue_idle();
    expect_t e;
    e = '0;
    issue_pair(1'b0, '0, '0, e);
  endtask

  task automatic run_trace();
    int gap_len;
    expect_t e;
    for (int i = 0; i < line_count; i++) begin
      gap_len = 0;
      if (tr_gap[i] != 0)
        gap_len = {$random(seed)} % 3;
      for (int g = 0; g < gap_len; g++)
        issue_idle();
      e = '0;
      e.real_op = 1'b1;
      e.test = tr_test[i];
      e.last = (i == line_count - 1) ? 1'b1 : (tr_test[i + 1] != tr_test[i]);
      for (int l = 0; l < 2; l++) begin
        e.write[l] = tr_write[i][l];
        e.dst[l] = tr_dst[i][l];
        e.data[l] = tr_data[i][l];
      end
      issue_pair(1'b1, tr_inst[i][0], tr_inst[i][1], e);
    end
  endtask

  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while (pending_real > 0 && cycles < DRAIN_TIMEOUT) begin
      issue_idle();
      cycles++;
    end
    if (pending_real > 0) begin
      $display("timeout: %0d issued pairs never reached write-back", pending_real);
      error_count++;
    end
  endtask

  task automatic wait_reset(output logic done);
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    done = (reset === 1'b0);
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////
  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  task automatic finish_test(input logic [31:0] test);
    test_count++;
    if (test_errors == 0) begin
      $display("test %0d passed", test);
    end else begin
      failed_tests++;
      $display("test %0d failed with %0d errors", test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic check_entry(input expect_t e);
    for (int l = 0; l < `NUM_LANES; l++) begin
      check_count++;
      if (wb_write[l] !== e.write[l]) begin
        $display("mismatch at %0t: wb_write[%0d] got %b expected %b",
                 $time, l, wb_write[l], e.write[l]);
        note_error();
      end else if (e.write[l]) begin
        if (wb_dst[l] !== e.dst[l]) begin
          $display("mismatch at %0t: wb_dst[%0d] got %0d expected %0d",
                   $time, l, wb_dst[l], e.dst[l]);
          note_error();
        end
        if (wb_data[l] !== e.data[l]) begin
          $display("mismatch at %0t: wb_data[%0d] got %h expected %h",
                   $time, l, wb_data[l], e.data[l]);
          note_error();
        end
      end
    end
    if (e.real_op)
      pending_real--;
    if (e.real_op && e.last)
      finish_test(e.test);
  endtask

  // outputs of the entry driven two edges back are stable here
  always @(negedge clk) begin
    if (expect_q.size() > 2) begin
      cur_exp = expect_q.pop_front();
      check_entry(cur_exp);
    end
  end

  task automatic finish_run();
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  initial begin
    seed = 2706;
    issue_valid = 1'b0;
    instruction = '0;
    load_trace();
    wait_reset(released);
    if (!released) begin
      $display("timeout: reset was never released");
      error_count++;
    end else begin
      // quiet cycles right after reset
      for (int i = 0; i < 3; i++)
        issue_idle();
      run_trace();
      drain_pipeline();
    end
    finish_run();
  end

endmodule
